// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [9:0]      ctrl_t;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;
    localparam alu_op_t ALU_LUI = 4'd6;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_WORD = 3'b010; // lw / sw

    // bit positions in ctrl_t
    localparam int CTRL_USE_IMM   = 0;
    localparam int CTRL_USE_PC    = 1;
    localparam int CTRL_IS_LOAD   = 2;
    localparam int CTRL_IS_STORE  = 3;
    localparam int CTRL_IS_WORD   = 4;
    localparam int CTRL_IS_BRANCH = 5;
    localparam int CTRL_IS_JAL    = 6;
    localparam int CTRL_IS_JALR   = 7;
    localparam int CTRL_REG_WE    = 8;
    localparam int CTRL_IS_EBREAK = 9;

    localparam xlen_t  RESET_PC     = 64'h0000_0000_8000_0000;
    localparam instr_t EBREAK_INSTR = 32'h0010_0073;
    localparam int     DMEM_WORDS   = 256;
    localparam int     DMEM_AW      = $clog2(DMEM_WORDS);

endpackage

// File: hdl/pipe_if.sv
`timescale 1ns/100ps

interface ex_mem_if import rv_pkg::*; ();
    logic      valid;
    reg_addr_t rd;
    xlen_t     result; // alu result or memory address
    xlen_t     store_data;
    logic      is_load;
    logic      is_store;
    logic      is_word;
    logic      reg_we;
    xlen_t     pc;
    logic      is_ebreak;

    modport ex_mp (output valid, rd, result, store_data, is_load, is_store, is_word,
                   reg_we, pc, is_ebreak);
    modport mem_mp (input valid, rd, result, store_data, is_load, is_store, is_word,
                    reg_we, pc, is_ebreak);
endinterface

interface wb_if import rv_pkg::*; ();
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
    logic      reg_we;
    xlen_t     pc;
    logic      is_ebreak;

    modport wb_src (output valid, rd, data, reg_we, pc, is_ebreak);
    modport wb_dst (input valid, rd, data, reg_we, pc, is_ebreak);
endinterface

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall_i,
    input  logic   redirect_i,
    input  xlen_t  redirect_pc_i,
    input  logic   halt_i,
    input  instr_t imem_data_i,
    output xlen_t  imem_addr_o,
    output logic   id_valid_o,
    output instr_t id_instr_o,
    output xlen_t  id_pc_o
);

    xlen_t pc_q;
    logic  halted_q; // ebreak seen in decode, fetch stays off

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= RESET_PC;
            id_valid_o <= 1'b0;
            halted_q   <= 1'b0;
        end else if (redirect_i) begin
            pc_q       <= redirect_pc_i;
            id_valid_o <= 1'b0;
        end else if (halt_i || halted_q) begin
            halted_q   <= 1'b1;
            id_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_q       <= pc_q + 64'd4;
            id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_instr_o <= imem_data_i;
            id_pc_o    <= pc_q;
        end
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    wb_if.wb_dst      wb,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o
);

    xlen_t regs [32];
    logic  wr_en;

    assign wr_en = wb.valid && wb.reg_we && (wb.rd != '0);

    function automatic xlen_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wr_en && (wb.rd == addr))
            return wb.data; // write-through
        return regs[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_i);
    assign rs2_data_o = read_port(rs2_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/100ps

module decode_unit import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_i,
    input  instr_t     instr_i,
    input  xlen_t      pc_i,
    input  logic       flush_i,
    input  xlen_t      rs1_data_i,
    input  xlen_t      rs2_data_i,
    output reg_addr_t  rs1_o,
    output reg_addr_t  rs2_o,
    output logic       stall_o,
    output logic       halt_o,
    output logic       ex_valid_o,
    output xlen_t      ex_pc_o,
    output xlen_t      ex_imm_o,
    output xlen_t      ex_rs1_val_o,
    output xlen_t      ex_rs2_val_o,
    output reg_addr_t  ex_rs1_o,
    output reg_addr_t  ex_rs2_o,
    output reg_addr_t  ex_rd_o,
    output alu_op_t    ex_alu_op_o,
    output ctrl_t      ex_ctrl_o,
    output logic [2:0] ex_funct3_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    xlen_t      imm;
    ctrl_t      ctrl;
    alu_op_t    alu_op;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rd     = instr_i[11:7];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl    = '0;
        alu_op  = ALU_ADD;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm     = {{52{instr_i[31]}}, instr_i[31:20]}; // I-type
        case (opcode)
            OPC_OP: begin
                ctrl[CTRL_REG_WE] = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                alu_op  = alu_from_f3(funct3, instr_i[30]);
            end
            OPC_OP_IMM: begin
                ctrl[CTRL_REG_WE]  = 1'b1;
                ctrl[CTRL_USE_IMM] = 1'b1;
                use_rs1 = 1'b1;
                alu_op  = alu_from_f3(funct3, 1'b0);
            end
            OPC_LUI: begin
                ctrl[CTRL_REG_WE]  = 1'b1;
                ctrl[CTRL_USE_IMM] = 1'b1;
                alu_op = ALU_LUI;
                imm    = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                ctrl[CTRL_REG_WE]  = 1'b1;
                ctrl[CTRL_USE_IMM] = 1'b1;
                ctrl[CTRL_IS_LOAD] = 1'b1;
                ctrl[CTRL_IS_WORD] = (funct3 == F3_WORD);
                use_rs1 = 1'b1;
            end
            OPC_STORE: begin
                ctrl[CTRL_USE_IMM]  = 1'b1;
                ctrl[CTRL_IS_STORE] = 1'b1;
                ctrl[CTRL_IS_WORD]  = (funct3 == F3_WORD);
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_BRANCH: begin
                ctrl[CTRL_IS_BRANCH] = 1'b1;
                ctrl[CTRL_USE_PC]    = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = {{51{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                           instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl[CTRL_REG_WE] = 1'b1;
                ctrl[CTRL_IS_JAL] = 1'b1;
                ctrl[CTRL_USE_PC] = 1'b1;
                imm = {{43{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl[CTRL_REG_WE]  = 1'b1;
                ctrl[CTRL_IS_JALR] = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_SYSTEM: begin
                ctrl[CTRL_IS_EBREAK] = (instr_i == EBREAK_INSTR);
            end
            default: ;
        endcase
    end

    // load in execute feeding this instruction
    assign stall_o = valid_i && ex_valid_o && ex_ctrl_o[CTRL_IS_LOAD] && (ex_rd_o != '0)
                     && ((use_rs1 && (rs1_o == ex_rd_o)) || (use_rs2 && (rs2_o == ex_rd_o)));

    assign halt_o = valid_i && ctrl[CTRL_IS_EBREAK] && !flush_i;

    always_ff @(posedge clk) begin
        if (rst)
            ex_valid_o <= 1'b0;
        else
            ex_valid_o <= valid_i && !stall_o && !flush_i; // bubble on stall or flush
    end

    always_ff @(posedge clk) begin
        ex_pc_o      <= pc_i;
        ex_imm_o     <= imm;
        ex_rs1_val_o <= rs1_data_i;
        ex_rs2_val_o <= rs2_data_i;
        ex_rs1_o     <= rs1_o;
        ex_rs2_o     <= rs2_o;
        ex_rd_o      <= rd;
        ex_alu_op_o  <= alu_op;
        ex_ctrl_o    <= ctrl;
        ex_funct3_o  <= funct3;
    end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/100ps

module execute_unit import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ex_valid_i,
    input  xlen_t      ex_pc_i,
    input  xlen_t      ex_imm_i,
    input  xlen_t      ex_rs1_val_i,
    input  xlen_t      ex_rs2_val_i,
    input  reg_addr_t  ex_rs1_i,
    input  reg_addr_t  ex_rs2_i,
    input  reg_addr_t  ex_rd_i,
    input  alu_op_t    ex_alu_op_i,
    input  ctrl_t      ex_ctrl_i,
    input  logic [2:0] ex_funct3_i,
    wb_if.wb_dst       wb,
    ex_mem_if.ex_mp    exm,
    output logic       redirect_o,
    output xlen_t      redirect_pc_o
);

    xlen_t op_a;
    xlen_t op_b;
    xlen_t rs2_fwd;
    xlen_t alu_res;
    xlen_t target;
    logic  taken;
    logic  is_jump;

    function automatic xlen_t fwd(input reg_addr_t r, input xlen_t rf_val);
        if (exm.valid && !exm.is_load && exm.reg_we && (exm.rd != '0) && (exm.rd == r))
            return exm.result;
        if (wb.valid && wb.reg_we && (wb.rd != '0) && (wb.rd == r))
            return wb.data;
        return rf_val;
    endfunction

    assign op_a    = fwd(ex_rs1_i, ex_rs1_val_i);
    assign rs2_fwd = fwd(ex_rs2_i, ex_rs2_val_i);
    assign op_b    = ex_ctrl_i[CTRL_USE_IMM] ? ex_imm_i : rs2_fwd;

    always_comb begin
        case (ex_alu_op_i)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ex_funct3_i)
            F3_BEQ:  taken = (op_a == rs2_fwd);
            F3_BNE:  taken = (op_a != rs2_fwd);
            F3_BLT:  taken = $signed(op_a) < $signed(rs2_fwd);
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = ex_ctrl_i[CTRL_IS_JAL] || ex_ctrl_i[CTRL_IS_JALR];
    // pc-relative for branch and jal, rs1-based for jalr
    assign target  = (ex_ctrl_i[CTRL_USE_PC] ? ex_pc_i : op_a) + ex_imm_i;

    assign redirect_o    = ex_valid_i && ((ex_ctrl_i[CTRL_IS_BRANCH] && taken) || is_jump);
    assign redirect_pc_o = {target[XLEN-1:1], target[0] && !ex_ctrl_i[CTRL_IS_JALR]};

    always_ff @(posedge clk) begin
        if (rst)
            exm.valid <= 1'b0;
        else
            exm.valid <= ex_valid_i;
    end

    always_ff @(posedge clk) begin
        exm.rd         <= ex_rd_i;
        exm.result     <= is_jump ? ex_pc_i + 64'd4 : alu_res; // link for jumps
        exm.store_data <= rs2_fwd;
        exm.is_load    <= ex_ctrl_i[CTRL_IS_LOAD];
        exm.is_store   <= ex_ctrl_i[CTRL_IS_STORE];
        exm.is_word    <= ex_ctrl_i[CTRL_IS_WORD];
        exm.reg_we     <= ex_ctrl_i[CTRL_REG_WE];
        exm.pc         <= ex_pc_i;
        exm.is_ebreak  <= ex_ctrl_i[CTRL_IS_EBREAK];
    end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    ex_mem_if.mem_mp exm,
    wb_if.wb_src     wb
);

    xlen_t                dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0]   idx;
    xlen_t                rd_word;
    logic [31:0]          rd_half;
    xlen_t                load_data;

    assign idx       = exm.result[3 +: DMEM_AW]; // doubleword index, wraps
    assign rd_word   = dmem[idx];
    assign rd_half   = exm.result[2] ? rd_word[63:32] : rd_word[31:0];
    assign load_data = exm.is_word ? {{32{rd_half[31]}}, rd_half} : rd_word;

    always_ff @(posedge clk) begin
        if (exm.valid && exm.is_store) begin
            if (!exm.is_word)
                dmem[idx] <= exm.store_data;
            else if (exm.result[2])
                dmem[idx][63:32] <= exm.store_data[31:0];
            else
                dmem[idx][31:0] <= exm.store_data[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            wb.valid <= 1'b0;
        else
            wb.valid <= exm.valid;
    end

    always_ff @(posedge clk) begin
        wb.rd        <= exm.rd;
        wb.data      <= exm.is_load ? load_data : exm.result;
        wb.reg_we    <= exm.reg_we;
        wb.pc        <= exm.pc;
        wb.is_ebreak <= exm.is_ebreak;
    end

endmodule

// File: hdl/core_top.sv
`timescale 1ns/100ps

module core_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  instr_t    imem_data_i,
    output xlen_t     imem_addr_o,
    output logic      retire_valid_o,
    output xlen_t     retire_pc_o,
    output logic      retire_we_o,
    output reg_addr_t retire_rd_o,
    output xlen_t     retire_data_o,
    output logic      ebreak_o
);

    logic       id_valid, stall, halt, redirect;
    instr_t     id_instr;
    xlen_t      id_pc, redirect_pc, rs1_data, rs2_data;
    reg_addr_t  rs1, rs2;
    logic       ex_valid;
    xlen_t      ex_pc, ex_imm, ex_rs1_val, ex_rs2_val;
    reg_addr_t  ex_rs1, ex_rs2, ex_rd;
    alu_op_t    ex_alu_op;
    ctrl_t      ex_ctrl;
    logic [2:0] ex_funct3;
    logic       ebreak_q;

    ex_mem_if i_ex_mem ();
    wb_if     i_wb ();

    fetch_unit i_fetch (
        .clk, .rst,
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halt_i        (halt),
        .imem_data_i,
        .imem_addr_o,
        .id_valid_o    (id_valid),
        .id_instr_o    (id_instr),
        .id_pc_o       (id_pc)
    );

    reg_file i_reg_file (
        .clk, .rst,
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb         (i_wb.wb_dst),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    decode_unit i_decode (
        .clk, .rst,
        .valid_i      (id_valid),
        .instr_i      (id_instr),
        .pc_i         (id_pc),
        .flush_i      (redirect),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .stall_o      (stall),
        .halt_o       (halt),
        .ex_valid_o   (ex_valid),
        .ex_pc_o      (ex_pc),
        .ex_imm_o     (ex_imm),
        .ex_rs1_val_o (ex_rs1_val),
        .ex_rs2_val_o (ex_rs2_val),
        .ex_rs1_o     (ex_rs1),
        .ex_rs2_o     (ex_rs2),
        .ex_rd_o      (ex_rd),
        .ex_alu_op_o  (ex_alu_op),
        .ex_ctrl_o    (ex_ctrl),
        .ex_funct3_o  (ex_funct3)
    );

    execute_unit i_execute (
        .clk, .rst,
        .ex_valid_i    (ex_valid),
        .ex_pc_i       (ex_pc),
        .ex_imm_i      (ex_imm),
        .ex_rs1_val_i  (ex_rs1_val),
        .ex_rs2_val_i  (ex_rs2_val),
        .ex_rs1_i      (ex_rs1),
        .ex_rs2_i      (ex_rs2),
        .ex_rd_i       (ex_rd),
        .ex_alu_op_i   (ex_alu_op),
        .ex_ctrl_i     (ex_ctrl),
        .ex_funct3_i   (ex_funct3),
        .wb            (i_wb.wb_dst),
        .exm           (i_ex_mem.ex_mp),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    mem_stage i_mem (
        .clk, .rst,
        .exm (i_ex_mem.mem_mp),
        .wb  (i_wb.wb_src)
    );

    assign retire_valid_o = i_wb.valid;
    assign retire_pc_o    = i_wb.pc;
    assign retire_we_o    = i_wb.reg_we;
    assign retire_rd_o    = i_wb.rd;
    assign retire_data_o  = i_wb.data;

    // high from the ebreak retire until reset
    assign ebreak_o = ebreak_q || (i_wb.valid && i_wb.is_ebreak);

    always_ff @(posedge clk) begin
        if (rst)
            ebreak_q <= 1'b0;
        else if (i_wb.valid && i_wb.is_ebreak)
            ebreak_q <= 1'b1;
    end

endmodule

// File: tests/tb_core_chk.sv
`timescale 1ns/100ps

module tb_core_chk (
    input logic clk,
    input logic rst,
    input logic retire_valid_i,
    input logic ebreak_i
);

    int fail_count = 0; // read by the testbench at the end

    reset_quiet: assert property (@(posedge clk) $past(rst) |-> !retire_valid_i && !ebreak_i)
        else begin
            $error("retire or ebreak high in the cycle after reset");
            fail_count++;
        end

    ebreak_sticky: assert property (@(posedge clk) $fell(ebreak_i) |-> $past(rst))
        else begin
            $error("ebreak_o fell without a reset");
            fail_count++;
        end

    // ebreak is the last retire
    halt_quiet: assert property (@(posedge clk) disable iff (rst)
                                 $past(ebreak_i) |-> !retire_valid_i)
        else begin
            $error("instruction retired after ebreak");
            fail_count++;
        end

endmodule

bind core_top tb_core_chk i_chk (
    .clk            (clk),
    .rst            (rst),
    .retire_valid_i (retire_valid_o),
    .ebreak_i       (ebreak_o)
);

// File: tests/tb_core.sv
`timescale 1ns/100ps

module tb_core import rv_pkg::*; ();

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    instr_t    imem_data;
    xlen_t     imem_addr;
    xlen_t     imem_off;
    logic      retire_valid;
    xlen_t     retire_pc;
    logic      retire_we;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    logic      ebreak;

    instr_t    imem [64];
    instr_t    prog [$];
    xlen_t     exp_pc [$];
    logic      exp_we [$];
    reg_addr_t exp_rd [$];
    xlen_t     exp_data [$];
    xlen_t     ret_pc [$];
    logic      ret_we [$];
    reg_addr_t ret_rd [$];
    xlen_t     ret_data [$];

    logic [31:0] lcg_state = 32'h7542;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    core_top i_core_top (
        .clk            (clk),
        .rst            (rst),
        .imem_data_i    (imem_data),
        .imem_addr_o    (imem_addr),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_we_o    (retire_we),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data),
        .ebreak_o       (ebreak)
    );

    always #50 clk = ~clk;

    assign imem_off  = imem_addr - RESET_PC;
    assign imem_data = imem[imem_off[7:2]]; // combinational fetch port

    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: no ebreak seen after %0d cycles", cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic xlen_t sign_extend12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(input opcode_t opc, input reg_addr_t rd,
                                      input logic [2:0] f3, input reg_addr_t rs1,
                                      input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(input logic [2:0] f3, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t u_type(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic instr_t j_type(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic compare_value(input string sig, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", sig, got, exp);
            error_count++;
        end
    endtask

    task automatic start_program();
        prog.delete();
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_data.delete();
    endtask

    task automatic add_expected(input int slot, input logic we, input reg_addr_t rd,
                                input xlen_t data);
        exp_pc.push_back(RESET_PC + 64'(4 * slot));
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic run_program(input string name);
        int   start_errors;
        int   extra;
        int   n;
        logic seen;
        start_errors = error_count;
        extra = 0;
        seen = 1'b0;
        // unused slots hold addi x31 with the slot index
        for (int i = 0; i < 64; i++)
            imem[i] = (i < prog.size()) ? prog[i] : i_type(OPC_OP_IMM, 5'd31, F3_ADD, 5'd0, 12'(i));
        cycle_limit += 8 * prog.size() + 40;
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        ret_pc.delete();
        ret_we.delete();
        ret_rd.delete();
        ret_data.delete();
        while (!seen) begin
            @(negedge clk);
            if (retire_valid) begin
                ret_pc.push_back(retire_pc);
                ret_we.push_back(retire_we);
                ret_rd.push_back(retire_rd);
                ret_data.push_back(retire_data);
            end
            if (ebreak) begin
                seen = 1'b1;
                if (!retire_valid) begin
                    $display("ebreak_o rose while no instruction retired");
                    error_count++;
                end
            end
        end
        repeat (4) begin
            @(negedge clk);
            if (retire_valid)
                extra++;
        end
        if (extra != 0) begin
            $display("%0d instructions retired after the ebreak", extra);
            error_count++;
        end
        if (ret_pc.size() != exp_pc.size()) begin
            $display("retired %0d instructions, expected %0d", ret_pc.size(), exp_pc.size());
            error_count++;
        end
        n = (ret_pc.size() < exp_pc.size()) ? ret_pc.size() : exp_pc.size();
        for (int i = 0; i < n; i++) begin
            compare_value($sformatf("retire_pc_o[%0d]", i), ret_pc[i], exp_pc[i]);
            compare_value($sformatf("retire_we_o[%0d]", i), 64'(ret_we[i]), 64'(exp_we[i]));
            if (exp_we[i])
                compare_value($sformatf("retire_rd_o[%0d]", i), 64'(ret_rd[i]), 64'(exp_rd[i]));
            if (exp_we[i] && exp_rd[i] != '0) // x0 writes are dropped
                compare_value($sformatf("retire_data_o[%0d]", i), ret_data[i], exp_data[i]);
        end
        tests_run++;
        if (error_count != start_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - start_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_alu_chain();
        logic [11:0] i0;
        logic [11:0] i1;
        logic [19:0] u;
        xlen_t       r [11];
        start_program();
        i0 = 12'(next_random() >> 16);
        i1 = 12'(next_random() >> 16);
        u  = 20'(next_random() >> 8);
        prog.push_back(i_type(OPC_OP_IMM, 1, F3_ADD, 0, i0));
        prog.push_back(i_type(OPC_OP_IMM, 2, F3_ADD, 1, i1));
        prog.push_back(r_type(7'b0000000, 1, 2, F3_ADD, 3));
        prog.push_back(r_type(7'b0100000, 2, 3, F3_ADD, 4)); // sub
        prog.push_back(r_type(7'b0000000, 3, 4, F3_AND, 5));
        prog.push_back(r_type(7'b0000000, 2, 5, F3_OR, 6));
        prog.push_back(r_type(7'b0000000, 4, 6, F3_XOR, 7));
        prog.push_back(r_type(7'b0000000, 6, 7, F3_SLT, 8));
        prog.push_back(u_type(9, u));
        prog.push_back(r_type(7'b0000000, 8, 9, F3_ADD, 10));
        prog.push_back(EBREAK_INSTR);
        r[1]  = sign_extend12(i0);
        r[2]  = r[1] + sign_extend12(i1);
        r[3]  = r[2] + r[1];
        r[4]  = r[3] - r[2];
        r[5]  = r[4] & r[3];
        r[6]  = r[5] | r[2];
        r[7]  = r[6] ^ r[4];
        r[8]  = ($signed(r[7]) < $signed(r[6])) ? 64'd1 : 64'd0;
        r[9]  = {{32{u[19]}}, u, 12'h000};
        r[10] = r[9] + r[8];
        for (int k = 1; k <= 10; k++)
            add_expected(k - 1, 1'b1, 5'(k), r[k]);
        add_expected(10, 1'b0, 0, 0);
        run_program("alu_chain");
    endtask

    task automatic test_memory();
        logic [11:0] i0;
        logic [19:0] u;
        xlen_t       v1;
        xlen_t       v2;
        start_program();
        i0 = 12'(next_random() >> 16);
        u  = 20'(next_random() >> 8);
        prog.push_back(u_type(1, u));
        prog.push_back(i_type(OPC_OP_IMM, 1, F3_ADD, 1, i0));
        prog.push_back(i_type(OPC_OP_IMM, 2, F3_ADD, 0, 12'hffb)); // -5
        prog.push_back(s_type(3'b011, 1, 0, 12'h100)); // sd
        prog.push_back(s_type(F3_WORD, 2, 0, 12'h10c)); // upper half of 0x108
        prog.push_back(i_type(OPC_LOAD, 3, 3'b011, 0, 12'h100)); // ld
        prog.push_back(i_type(OPC_LOAD, 4, F3_WORD, 0, 12'h10c));
        prog.push_back(r_type(7'b0000000, 3, 4, F3_ADD, 5)); // load-use
        prog.push_back(s_type(F3_WORD, 1, 0, 12'h108));
        prog.push_back(i_type(OPC_LOAD, 6, 3'b011, 0, 12'h108));
        prog.push_back(i_type(OPC_LOAD, 7, F3_WORD, 0, 12'h108));
        prog.push_back(EBREAK_INSTR);
        v1 = {{32{u[19]}}, u, 12'h000};
        add_expected(0, 1'b1, 1, v1);
        v1 = v1 + sign_extend12(i0);
        v2 = 64'hffff_ffff_ffff_fffb;
        add_expected(1, 1'b1, 1, v1);
        add_expected(2, 1'b1, 2, v2);
        add_expected(3, 1'b0, 0, 0);
        add_expected(4, 1'b0, 0, 0);
        add_expected(5, 1'b1, 3, v1);
        add_expected(6, 1'b1, 4, v2);
        add_expected(7, 1'b1, 5, v1 + v2);
        add_expected(8, 1'b0, 0, 0);
        add_expected(9, 1'b1, 6, {32'hffff_fffb, v1[31:0]});
        add_expected(10, 1'b1, 7, {{32{v1[31]}}, v1[31:0]});
        add_expected(11, 1'b0, 0, 0);
        run_program("memory");
    endtask

    task automatic test_branches();
        start_program();
        prog.push_back(i_type(OPC_OP_IMM, 1, F3_ADD, 0, 12'd5));
        prog.push_back(i_type(OPC_OP_IMM, 2, F3_ADD, 0, 12'd5));
        prog.push_back(i_type(OPC_OP_IMM, 3, F3_ADD, 0, 12'hffd)); // -3
        prog.push_back(b_type(F3_BEQ, 1, 2, 13'd8)); // taken
        prog.push_back(i_type(OPC_OP_IMM, 10, F3_ADD, 0, 12'd1));
        prog.push_back(b_type(F3_BNE, 1, 2, 13'd8)); // not taken
        prog.push_back(i_type(OPC_OP_IMM, 11, F3_ADD, 0, 12'd2));
        prog.push_back(b_type(F3_BLT, 3, 1, 13'd12)); // taken
        prog.push_back(i_type(OPC_OP_IMM, 12, F3_ADD, 0, 12'd3));
        prog.push_back(i_type(OPC_OP_IMM, 12, F3_ADD, 0, 12'd4));
        prog.push_back(b_type(F3_BLT, 1, 3, 13'd8)); // not taken
        prog.push_back(b_type(F3_BNE, 1, 3, 13'd8)); // taken
        prog.push_back(i_type(OPC_OP_IMM, 13, F3_ADD, 0, 12'd5));
        prog.push_back(b_type(F3_BEQ, 1, 3, 13'd8)); // not taken
        prog.push_back(r_type(7'b0000000, 1, 11, F3_ADD, 14));
        prog.push_back(EBREAK_INSTR);
        add_expected(0, 1'b1, 1, 64'd5);
        add_expected(1, 1'b1, 2, 64'd5);
        add_expected(2, 1'b1, 3, 64'hffff_ffff_ffff_fffd);
        add_expected(3, 1'b0, 0, 0);
        add_expected(5, 1'b0, 0, 0);
        add_expected(6, 1'b1, 11, 64'd2);
        add_expected(7, 1'b0, 0, 0);
        add_expected(10, 1'b0, 0, 0);
        add_expected(11, 1'b0, 0, 0);
        add_expected(13, 1'b0, 0, 0);
        add_expected(14, 1'b1, 14, 64'd7);
        add_expected(15, 1'b0, 0, 0);
        run_program("branches");
    endtask

    task automatic test_jumps();
        start_program();
        prog.push_back(j_type(1, 21'd12)); // to slot 3
        prog.push_back(i_type(OPC_OP_IMM, 10, F3_ADD, 0, 12'd1));
        prog.push_back(i_type(OPC_OP_IMM, 10, F3_ADD, 0, 12'd2));
        prog.push_back(i_type(OPC_JALR, 5, 3'b000, 1, 12'd21)); // odd target lands on slot 6
        prog.push_back(i_type(OPC_OP_IMM, 11, F3_ADD, 0, 12'd3));
        prog.push_back(i_type(OPC_OP_IMM, 11, F3_ADD, 0, 12'd4));
        prog.push_back(r_type(7'b0000000, 1, 5, F3_ADD, 6));
        prog.push_back(i_type(OPC_JALR, 8, 3'b000, 5, 12'd25)); // to slot 10
        prog.push_back(i_type(OPC_OP_IMM, 12, F3_ADD, 0, 12'd5));
        prog.push_back(i_type(OPC_OP_IMM, 12, F3_ADD, 0, 12'd6));
        prog.push_back(EBREAK_INSTR);
        add_expected(0, 1'b1, 1, RESET_PC + 64'd4);
        add_expected(3, 1'b1, 5, RESET_PC + 64'd16);
        add_expected(6, 1'b1, 6, RESET_PC + RESET_PC + 64'd20);
        add_expected(7, 1'b1, 8, RESET_PC + 64'd32);
        add_expected(10, 1'b0, 0, 0);
        run_program("jumps");
    endtask

    task automatic test_x0_writes();
        start_program();
        prog.push_back(i_type(OPC_OP_IMM, 1, F3_ADD, 0, 12'd77));
        prog.push_back(i_type(OPC_OP_IMM, 0, F3_ADD, 1, 12'd100));
        prog.push_back(r_type(7'b0000000, 1, 0, F3_ADD, 2));
        prog.push_back(i_type(OPC_OP_IMM, 3, F3_ADD, 0, 12'd5));
        prog.push_back(r_type(7'b0000000, 0, 0, F3_OR, 4));
        prog.push_back(EBREAK_INSTR);
        add_expected(0, 1'b1, 1, 64'd77);
        add_expected(1, 1'b1, 0, 0);
        add_expected(2, 1'b1, 2, 64'd77);
        add_expected(3, 1'b1, 3, 64'd5);
        add_expected(4, 1'b1, 4, 64'd0);
        add_expected(5, 1'b0, 0, 0);
        run_program("x0_writes");
    endtask

    task automatic test_ebreak_halt();
        start_program();
        prog.push_back(i_type(OPC_OP_IMM, 1, F3_ADD, 0, 12'd1));
        prog.push_back(b_type(F3_BEQ, 0, 0, 13'd8));
        prog.push_back(EBREAK_INSTR); // squashed ebreak must not halt
        prog.push_back(i_type(OPC_OP_IMM, 2, F3_ADD, 0, 12'd2));
        prog.push_back(EBREAK_INSTR);
        prog.push_back(i_type(OPC_OP_IMM, 3, F3_ADD, 0, 12'd3));
        prog.push_back(i_type(OPC_OP_IMM, 4, F3_ADD, 0, 12'd4));
        add_expected(0, 1'b1, 1, 64'd1);
        add_expected(1, 1'b0, 0, 0);
        add_expected(3, 1'b1, 2, 64'd2);
        add_expected(4, 1'b0, 0, 0);
        run_program("ebreak_halt");
    endtask

    initial begin
        int total_errors;
        test_alu_chain();
        test_memory();
        test_branches();
        test_jumps();
        test_x0_writes();
        test_ebreak_halt();
        total_errors = error_count + i_core_top.i_chk.fail_count;
        $display("tests: %0d run, %0d failed, %0d check errors, %0d assertion errors",
                 tests_run, tests_failed, error_count, i_core_top.i_chk.fail_count);
        if (total_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb.f
hdl/rv_pkg.sv
hdl/pipe_if.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/mem_stage.sv
hdl/core_top.sv
tests/tb_core_chk.sv
tests/tb_core.sv
